// ==== files.f ====
+incdir+source
source/calc_pkg.sv
source/operand_entry.sv
source/calc_datapath.sv
source/line_formatter.sv
source/calc_top.sv
tests/calc_checker.sv
tests/calc_tb.sv

// ==== tests/calc_tb.sv ====
`timescale 1ns/1ns
`include "calc_cfg.svh"

module calc_tb import calc_pkg::*; ();

	localparam int MAX_WAIT = 20; // cycles from show step to line_valid

	logic                           PB1;
	logic                           reset;
	logic                           cmd_load;
	logic                           step;
	logic                           hold;
	logic [`CALC_NIBBLE_W-1:0]      nibble;
	logic [`CALC_LINE_CHARS*8-1:0]  line_top;
	logic [`CALC_LINE_CHARS*8-1:0]  line_bottom;
	logic                           line_valid;

	logic [`CALC_WORD_W-1:0] model [`CALC_NUM_REGS]; // expected register contents
	logic [31:0]             rng_state;

	calc_top u_calc_top (
		.PB1         (PB1),
		.reset       (reset),
		.cmd_load    (cmd_load),
		.step        (step),
		.hold        (hold),
		.nibble      (nibble),
		.line_top    (line_top),
		.line_bottom (line_bottom),
		.line_valid  (line_valid)
	);

	bind calc_top calc_checker u_calc_checker (
		.PB1        (PB1),
		.reset      (reset),
		.hold       (hold),
		.line_valid (line_valid),
		.wr_en      (wr_en)
	);

	initial begin
		PB1 = 1'b0;
		forever #5 PB1 = ~PB1;
	end

	//////////////////////////////
	// helpers
	function logic [31:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	// ascii '0'/'1', msb first, padded with blanks
	function automatic logic [127:0] addr_text(input logic [4:0] a);
		logic [127:0] t;
		t = {16{8'h20}};
		for (int i = 0; i < 5; i++) t[127-8*i -: 8] = 8'h30 + a[4-i];
		return t;
	endfunction

	function automatic logic [127:0] word_text(input logic [15:0] w);
		logic [127:0] t;
		for (int i = 0; i < 16; i++) t[127-8*i -: 8] = 8'h30 + w[15-i];
		return t;
	endfunction

	task abort_run();
		$display("TESTS FAILED");
		$fatal(1, "stopped on first error");
	endtask

	task tick();
		@(posedge PB1);
		#1;
	endtask

	task automatic check_line(input string name, input logic [127:0] got, expected);
		assert (got === expected) else begin
			$display("Mismatch %s: got %h expected %h", name, got, expected);
			abort_run();
		end
	endtask

	task automatic do_step(input logic [3:0] nib);
		nibble = nib;
		step = 1'b1;
		tick();
		step = 1'b0;
		tick();
		tick();
	endtask

	task automatic load_cmd(input calc_op_e op);
		nibble = {1'b0, op};
		cmd_load = 1'b1;
		tick();
		cmd_load = 1'b0;
		tick();
	endtask

	task automatic enter_addr(input logic [4:0] a);
		do_step(a[4:1]);
		do_step({3'b000, a[0]});
	endtask

	// one full entry in schedule order, then the show step and the line checks
	task automatic run_entry(input calc_op_e op, input logic [4:0] a, b, w,
			input logic [15:0] data, input logic [3:0] amt, input bit load);
		logic [15:0]  wval;
		logic [127:0] exp_top;
		logic [127:0] exp_bot;
		int           waited;
		if (load) load_cmd(op);
		do_step(4'h0); // idle step 0
		if (op != OP_WRITE) enter_addr(a);
		if (op inside {OP_READ2, OP_WRITE_READ2, OP_LESS, OP_XOR}) enter_addr(b);
		if (!(op inside {OP_READ, OP_READ2})) enter_addr(w);
		if (op inside {OP_WRITE, OP_WRITE_READ, OP_WRITE_READ2}) begin
			for (int i = 3; i >= 0; i--) do_step(data[4*i +: 4]);
		end
		if (op == OP_SHIFT) do_step(amt);
		if (!(op inside {OP_READ, OP_READ2})) begin
			case (op)
				OP_LESS:  wval = ($signed(model[a]) < $signed(model[b])) ? 16'd1 : 16'd0;
				OP_XOR:   wval = model[a] ^ model[b];
				OP_SHIFT: wval = model[a] >> amt;
				default:  wval = data;
			endcase
			do_step(4'h0); // write step
			model[w] = wval;
		end
		case (op)
			OP_READ, OP_WRITE_READ: begin
				exp_top = addr_text(a);
				exp_bot = word_text(model[a]);
			end
			OP_READ2, OP_WRITE_READ2: begin
				exp_top = word_text(model[a]);
				exp_bot = word_text(model[b]);
			end
			default: begin
				exp_top = addr_text(w);
				exp_bot = word_text(wval);
			end
		endcase
		nibble = 4'h0;
		step = 1'b1;
		tick();
		step = 1'b0;
		waited = 0;
		while (line_valid !== 1'b1) begin
			if (waited >= MAX_WAIT) begin
				$display("line_valid never came after the show step");
				abort_run();
			end
			tick();
			waited++;
		end
		check_line("line_top", line_top, exp_top);
		check_line("line_bottom", line_bottom, exp_bot);
		tick();
	endtask

	// catch bound assertion failures as they happen
	always @(negedge PB1) begin
		if (u_calc_top.u_calc_checker.fail_count != 0) begin
			$display("bound checker reported an assertion failure");
			abort_run();
		end
	end

	//////////////////////////////
	// main sequence
	initial begin
		logic [31:0] r1;
		logic [31:0] r2;
		logic [4:0]  waddrs [8];
		calc_op_e    op;
		rng_state = 32'hcc240740;
		reset = 1'b1;
		cmd_load = 1'b0;
		step = 1'b0;
		hold = 1'b0;
		nibble = '0;
		for (int i = 0; i < `CALC_NUM_REGS; i++) model[i] = '0;
		repeat (10) tick();
		reset = 1'b0;
		tick();

		// cleared registers
		run_entry(OP_READ, 5'd0, 5'd0, 5'd0, 16'h0, 4'h0, 1'b1);
		run_entry(OP_READ, 5'd31, 5'd0, 5'd0, 16'h0, 4'h0, 1'b1);
		for (int i = 0; i < 3; i++) begin
			r1 = next_rand();
			run_entry(OP_READ, r1[4:0], 5'd0, 5'd0, 16'h0, 4'h0, 1'b1);
		end

		// writes then reads back
		for (int i = 0; i < 8; i++) begin
			r1 = next_rand();
			waddrs[i] = r1[4:0];
			run_entry(OP_WRITE, 5'd0, 5'd0, r1[4:0], r1[31:16], 4'h0, 1'b1);
		end
		for (int i = 0; i < 8; i++) run_entry(OP_READ, waddrs[i], 5'd0, 5'd0, 16'h0, 4'h0, 1'b1);
		for (int i = 0; i < 4; i++) begin
			run_entry(OP_READ2, waddrs[i], waddrs[7-i], 5'd0, 16'h0, 4'h0, 1'b1);
		end

		// less, xor, shift on fresh operands, result read back
		for (int k = 0; k < 3; k++) begin
			op = (k == 0) ? OP_LESS : (k == 1) ? OP_XOR : OP_SHIFT;
			for (int i = 0; i < 5; i++) begin
				r1 = next_rand();
				r2 = next_rand();
				run_entry(OP_WRITE, 5'd0, 5'd0, r1[4:0], r2[15:0], 4'h0, 1'b1);
				run_entry(OP_WRITE, 5'd0, 5'd0, r1[9:5], r2[31:16], 4'h0, 1'b1);
				run_entry(op, r1[4:0], r1[9:5], r1[14:10], 16'h0, r1[18:15], 1'b1);
				run_entry(OP_READ, r1[14:10], 5'd0, 5'd0, 16'h0, 4'h0, 1'b1);
			end
		end

		// write-and-read, every other pass with A on the write address
		for (int i = 0; i < 6; i++) begin
			r1 = next_rand();
			r2 = next_rand();
			run_entry(OP_WRITE_READ, r1[4:0], 5'd0, (i % 2 == 0) ? r1[4:0] : r1[9:5],
				r2[15:0], 4'h0, 1'b1);
			run_entry(OP_WRITE_READ2, r1[14:10], r1[19:15],
				(i % 2 == 0) ? r1[19:15] : r1[14:10], r2[31:16], 4'h0, 1'b1);
		end

		// hold in mid entry restarts the sequence
		load_cmd(OP_WRITE);
		do_step(4'h0);
		enter_addr(5'h15);
		do_step(4'ha);
		hold = 1'b1;
		for (int i = 0; i < 12; i++) begin
			r1 = next_rand();
			do_step(r1[3:0]);
		end
		hold = 1'b0;
		tick();
		r1 = next_rand();
		run_entry(OP_WRITE, 5'd0, 5'd0, r1[4:0], r1[31:16], 4'h0, 1'b0);
		run_entry(OP_READ, r1[4:0], 5'd0, 5'd0, 16'h0, 4'h0, 1'b1);

		repeat (3) tick();
		if (u_calc_top.u_calc_checker.fail_count == 0) begin
			$display("TESTS PASSED");
			$finish;
		end else begin
			$display("bound checker failures at end of run");
			abort_run();
		end
	end

endmodule

// ==== tests/calc_checker.sv ====
`timescale 1ns/1ns

module calc_checker (
	input logic PB1,
	input logic reset,
	input logic hold,
	input logic line_valid,
	input logic wr_en
);

	int fail_count = 0; // read by the testbench

	//////////////////////////////
	// line_valid is a single cycle pulse
	a_valid_single: assert property (@(posedge PB1) disable iff (reset)
		line_valid |=> !line_valid)
	else begin
		$error("line_valid high on two consecutive cycles");
		fail_count++;
	end

	// quiet during reset and in the cycle after it
	a_reset_quiet: assert property (@(posedge PB1)
		$past(reset) |-> !line_valid && !wr_en)
	else begin
		$error("line_valid or wr_en high during or right after reset");
		fail_count++;
	end

	// no show can get through a held entry
	a_hold_quiet: assert property (@(posedge PB1) disable iff (reset)
		$past(hold) && $past(hold, 2) |-> !line_valid)
	else begin
		$error("line_valid seen while hold was high");
		fail_count++;
	end

endmodule

// ==== source/calc_top.sv ====
`timescale 1ns/1ns
`include "calc_cfg.svh"

module calc_top import calc_pkg::*; (
	input  logic                        PB1,
	input  logic                        reset,
	input  logic                        cmd_load,
	input  logic                        step,
	input  logic                        hold,
	input  logic [`CALC_NIBBLE_W-1:0]    nibble,
	output logic [`CALC_LINE_CHARS*8-1:0] line_top,
	output logic [`CALC_LINE_CHARS*8-1:0] line_bottom,
	output logic                        line_valid
);

	calc_op_e                  op;
	calc_addr_t                rd_addr_a;
	calc_addr_t                rd_addr_b;
	calc_addr_t                wr_addr;
	calc_word_t                entry_data;
	logic [`CALC_NIBBLE_W-1:0] shift_amt;
	logic                      wr_en;
	logic                      show;
	calc_word_t                word_a;
	calc_word_t                word_b;
	calc_word_t                result;
	lcd_line_u                 top_u;
	lcd_line_u                 bottom_u;

	operand_entry u_operand_entry (
		.PB1        (PB1),
		.reset      (reset),
		.cmd_load   (cmd_load),
		.step       (step),
		.hold       (hold),
		.nibble     (nibble),
		.op         (op),
		.rd_addr_a  (rd_addr_a),
		.rd_addr_b  (rd_addr_b),
		.wr_addr    (wr_addr),
		.entry_data (entry_data),
		.shift_amt  (shift_amt),
		.wr_en      (wr_en),
		.show       (show)
	);

	calc_datapath u_calc_datapath (
		.PB1        (PB1),
		.reset      (reset),
		.op         (op),
		.rd_addr_a  (rd_addr_a),
		.rd_addr_b  (rd_addr_b),
		.wr_addr    (wr_addr),
		.entry_data (entry_data),
		.shift_amt  (shift_amt),
		.wr_en      (wr_en),
		.word_a     (word_a),
		.word_b     (word_b),
		.result     (result)
	);

	line_formatter u_line_formatter (
		.PB1         (PB1),
		.reset       (reset),
		.op          (op),
		.show        (show),
		.rd_addr_a   (rd_addr_a),
		.wr_addr     (wr_addr),
		.word_a      (word_a),
		.word_b      (word_b),
		.result      (result),
		.line_top    (top_u),
		.line_bottom (bottom_u),
		.line_valid  (line_valid)
	);

	// flat view out of the chip
	assign line_top    = top_u.flat;
	assign line_bottom = bottom_u.flat;

endmodule

// ==== source/line_formatter.sv ====
`timescale 1ns/1ns
`include "calc_cfg.svh"

module line_formatter import calc_pkg::*; (
	input  logic       PB1,
	input  logic       reset,
	input  calc_op_e   op,
	input  logic       show,
	input  calc_addr_t rd_addr_a,
	input  calc_addr_t wr_addr,
	input  calc_word_t word_a,
	input  calc_word_t word_b,
	input  calc_word_t result,
	output lcd_line_u  line_top,
	output lcd_line_u  line_bottom,
	output logic       line_valid
);

	localparam logic [7:0] CHAR_ZERO  = 8'h30;
	localparam logic [7:0] CHAR_ONE   = 8'h31;
	localparam logic [7:0] CHAR_SPACE = 8'h20;

	lcd_line_u next_top;
	lcd_line_u next_bottom;

	//////////////////////////////
	// address, msb first then blanks
	function automatic lcd_line_u addr_line(input calc_addr_t addr);
		lcd_line_u l;
		l.flat = {`CALC_LINE_CHARS{CHAR_SPACE}};
		for (int i = 0; i < `CALC_ADDR_W; i++) begin
			l.chars[i] = addr[`CALC_ADDR_W-1-i] ? CHAR_ONE : CHAR_ZERO;
		end
		return l;
	endfunction

	// full word, one character per bit
	function automatic lcd_line_u word_line(input calc_word_t word);
		lcd_line_u l;
		for (int i = 0; i < `CALC_LINE_CHARS; i++) begin
			l.chars[i] = word[`CALC_WORD_W-1-i] ? CHAR_ONE : CHAR_ZERO;
		end
		return l;
	endfunction

	always_comb begin
		case (op)
			OP_READ, OP_WRITE_READ: begin
				next_top    = addr_line(rd_addr_a);
				next_bottom = word_line(word_a);
			end
			OP_READ2, OP_WRITE_READ2: begin
				next_top    = word_line(word_a);
				next_bottom = word_line(word_b);
			end
			default: begin // write, less, xor, shift
				next_top    = addr_line(wr_addr);
				next_bottom = word_line(result);
			end
		endcase
	end

	always_ff @(posedge PB1) begin
		if (reset) begin
			line_top.flat    <= {`CALC_LINE_CHARS{CHAR_SPACE}};
			line_bottom.flat <= {`CALC_LINE_CHARS{CHAR_SPACE}};
			line_valid       <= 1'b0;
		end else begin
			line_valid <= show;
			if (show) begin
				line_top    <= next_top;
				line_bottom <= next_bottom;
			end
		end
	end

endmodule

// ==== source/calc_datapath.sv ====
`timescale 1ns/1ns
`include "calc_cfg.svh"

module calc_datapath import calc_pkg::*; (
	input  logic                     PB1,
	input  logic                     reset,
	input  calc_op_e                 op,
	input  calc_addr_t               rd_addr_a,
	input  calc_addr_t               rd_addr_b,
	input  calc_addr_t               wr_addr,
	input  calc_word_t               entry_data,
	input  logic [`CALC_NIBBLE_W-1:0] shift_amt,
	input  logic                     wr_en,
	output calc_word_t               word_a,
	output calc_word_t               word_b,
	output calc_word_t               result
);

	calc_word_t regs [`CALC_NUM_REGS];

	logic       a_less_b;
	calc_word_t xor_word;
	calc_word_t shift_word;
	calc_word_t wr_word;

	// two asynchronous read ports
	assign word_a = regs[rd_addr_a];
	assign word_b = regs[rd_addr_b];

	//////////////////////////////
	// result logic
	assign a_less_b   = $signed(word_a) < $signed(word_b);
	assign xor_word   = word_a ^ word_b;
	assign shift_word = word_a >> shift_amt;    // logical, zero fill

	always_comb begin
		case (op)
			OP_LESS:  wr_word = calc_word_t'(a_less_b);
			OP_XOR:   wr_word = xor_word;
			OP_SHIFT: wr_word = shift_word;
			default:  wr_word = entry_data;     // the three write commands
		endcase
	end

	// register file write, plus a copy of the stored word
	// the copy keeps the shown value stable when wr_addr is also A or B
	always_ff @(posedge PB1) begin
		if (reset) begin
			for (int i = 0; i < `CALC_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
			result <= '0;
		end else if (wr_en) begin
			regs[wr_addr] <= wr_word;
			result        <= wr_word;
		end
	end

endmodule

// ==== source/operand_entry.sv ====
`timescale 1ns/1ns
`include "calc_cfg.svh"

module operand_entry import calc_pkg::*; (
	input  logic                     PB1,
	input  logic                     reset,
	input  logic                     cmd_load,
	input  logic                     step,
	input  logic                     hold,
	input  logic [`CALC_NIBBLE_W-1:0] nibble,
	output calc_op_e                 op,
	output calc_addr_t               rd_addr_a,
	output calc_addr_t               rd_addr_b,
	output calc_addr_t               wr_addr,
	output calc_word_t               entry_data,
	output logic [`CALC_NIBBLE_W-1:0] shift_amt,
	output logic                     wr_en,
	output logic                     show
);

	// what a step event does at the current count
	localparam logic [3:0] ACT_NONE  = 4'd0;
	localparam logic [3:0] ACT_A_HI  = 4'd1;
	localparam logic [3:0] ACT_A_LO  = 4'd2;
	localparam logic [3:0] ACT_B_HI  = 4'd3;
	localparam logic [3:0] ACT_B_LO  = 4'd4;
	localparam logic [3:0] ACT_W_HI  = 4'd5;
	localparam logic [3:0] ACT_W_LO  = 4'd6;
	localparam logic [3:0] ACT_DATA  = 4'd7;
	localparam logic [3:0] ACT_SHAMT = 4'd8;
	localparam logic [3:0] ACT_WRITE = 4'd9;
	localparam logic [3:0] ACT_SHOW  = 4'd10;

	logic [3:0] count;    // step number, 0..12
	logic       step_q;
	logic       step_evt;
	logic [3:0] act;

	// rising edge of step, dropped while held or loading
	assign step_evt = step & ~step_q & ~hold & ~cmd_load;

	//////////////////////////////
	// per command step schedule
	always_comb begin
		act = ACT_NONE;
		case (op)
			OP_WRITE: begin
				case (count)
					4'd1:                   act = ACT_W_HI;
					4'd2:                   act = ACT_W_LO;
					4'd3, 4'd4, 4'd5, 4'd6: act = ACT_DATA;
					4'd7:                   act = ACT_WRITE;
					4'd8:                   act = ACT_SHOW;
					default:                act = ACT_NONE;
				endcase
			end
			OP_READ: begin
				case (count)
					4'd1:    act = ACT_A_HI;
					4'd2:    act = ACT_A_LO;
					4'd3:    act = ACT_SHOW;
					default: act = ACT_NONE;
				endcase
			end
			OP_READ2: begin
				case (count)
					4'd1:    act = ACT_A_HI;
					4'd2:    act = ACT_A_LO;
					4'd3:    act = ACT_B_HI;
					4'd4:    act = ACT_B_LO;
					4'd5:    act = ACT_SHOW;
					default: act = ACT_NONE;
				endcase
			end
			OP_WRITE_READ: begin
				case (count)
					4'd1:                   act = ACT_A_HI;
					4'd2:                   act = ACT_A_LO;
					4'd3:                   act = ACT_W_HI;
					4'd4:                   act = ACT_W_LO;
					4'd5, 4'd6, 4'd7, 4'd8: act = ACT_DATA;
					4'd9:                   act = ACT_WRITE;
					4'd10:                  act = ACT_SHOW;
					default:                act = ACT_NONE;
				endcase
			end
			OP_WRITE_READ2: begin
				case (count)
					4'd1:                    act = ACT_A_HI;
					4'd2:                    act = ACT_A_LO;
					4'd3:                    act = ACT_B_HI;
					4'd4:                    act = ACT_B_LO;
					4'd5:                    act = ACT_W_HI;
					4'd6:                    act = ACT_W_LO;
					4'd7, 4'd8, 4'd9, 4'd10: act = ACT_DATA;
					4'd11:                   act = ACT_WRITE;
					4'd12:                   act = ACT_SHOW;
					default:                 act = ACT_NONE;
				endcase
			end
			OP_LESS, OP_XOR: begin
				case (count)
					4'd1:    act = ACT_A_HI;
					4'd2:    act = ACT_A_LO;
					4'd3:    act = ACT_B_HI;
					4'd4:    act = ACT_B_LO;
					4'd5:    act = ACT_W_HI;
					4'd6:    act = ACT_W_LO;
					4'd7:    act = ACT_WRITE;
					4'd8:    act = ACT_SHOW;
					default: act = ACT_NONE;
				endcase
			end
			OP_SHIFT: begin
				case (count)
					4'd1:    act = ACT_A_HI;
					4'd2:    act = ACT_A_LO;
					4'd3:    act = ACT_W_HI;
					4'd4:    act = ACT_W_LO;
					4'd5:    act = ACT_SHAMT;
					4'd6:    act = ACT_WRITE;
					4'd7:    act = ACT_SHOW;
					default: act = ACT_NONE;
				endcase
			end
			default: act = ACT_NONE;
		endcase
	end

	//////////////////////////////
	// command, counter and pulses
	always_ff @(posedge PB1) begin
		if (reset) begin
			op     <= OP_WRITE;
			count  <= '0;
			step_q <= 1'b0;
			wr_en  <= 1'b0;
			show   <= 1'b0;
		end else begin
			step_q <= step;
			wr_en  <= step_evt && (act == ACT_WRITE);
			show   <= step_evt && (act == ACT_SHOW);
			if (cmd_load) begin
				op    <= calc_op_e'(nibble[2:0]);
				count <= '0;
			end else if (hold) begin
				count <= '0; // entry starts over on release
			end else if (step_evt) begin
				count <= (act == ACT_SHOW) ? 4'd0 : count + 4'd1;
			end
		end
	end

	// operand fields, filled nibble by nibble
	always_ff @(posedge PB1) begin
		if (step_evt) begin
			case (act)
				ACT_A_HI:  rd_addr_a[`CALC_ADDR_W-1:1] <= nibble;
				ACT_A_LO:  rd_addr_a[0] <= nibble[0];
				ACT_B_HI:  rd_addr_b[`CALC_ADDR_W-1:1] <= nibble;
				ACT_B_LO:  rd_addr_b[0] <= nibble[0];
				ACT_W_HI:  wr_addr[`CALC_ADDR_W-1:1] <= nibble;
				ACT_W_LO:  wr_addr[0] <= nibble[0];
				// first nibble ends up on top after four shifts
				ACT_DATA:  entry_data <= {entry_data[`CALC_WORD_W-`CALC_NIBBLE_W-1:0], nibble};
				ACT_SHAMT: shift_amt <= nibble;
				default:   ;
			endcase
		end
	end

endmodule

// ==== source/calc_pkg.sv ====
`include "calc_cfg.svh"

package calc_pkg;

	// command code, latched from nibble[2:0]
	typedef enum logic [2:0] {
		OP_WRITE       = 3'd0,
		OP_READ        = 3'd1,
		OP_READ2       = 3'd2,
		OP_WRITE_READ  = 3'd3,
		OP_WRITE_READ2 = 3'd4,
		OP_LESS        = 3'd5,
		OP_XOR         = 3'd6,
		OP_SHIFT       = 3'd7
	} calc_op_e;

	typedef logic [`CALC_WORD_W-1:0] calc_word_t;
	typedef logic [`CALC_ADDR_W-1:0] calc_addr_t;

	//////////////////////////////
	// display line, two views of the same 128 bits
	// chars[0] is the leftmost character, in the top byte
	typedef union packed {
		logic [`CALC_LINE_CHARS*8-1:0]     flat;
		logic [0:`CALC_LINE_CHARS-1][7:0] chars;
	} lcd_line_u;

endpackage

// ==== source/calc_cfg.svh ====
`ifndef CALC_CFG_SVH
`define CALC_CFG_SVH

// register file geometry
`define CALC_WORD_W 16
`define CALC_ADDR_W 5
`define CALC_NUM_REGS 32

// one entry step carries this many bits
`define CALC_NIBBLE_W 4

// display line, characters of 8 bits each
`define CALC_LINE_CHARS 16

`endif
